// ==== compile.f ====
source/textModePkg.sv
source/hostBusPkg.sv
source/memPortIf.sv
source/hostPort.sv
source/textMemory.sv
source/scanOut.sv
source/textDisplayTop.sv
test/textDisplay_chk.sv
test/textDisplayTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the text display testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module textDisplayTb -f compile.f

./obj_dir/VtextDisplayTb | tee sim.log

if grep -q -F '*** TEST FAILED ***' sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished without failure"

// ==== source/hostBusPkg.sv ====
// Host bus address map and request payload.
// Region in the top two address bits, then a per-region field layout.
`default_nettype none

package hostBusPkg;

	typedef logic [15:0] hostAddrT;
	typedef logic [31:0] hostWordT;
	typedef logic [1:0] regionT;
	typedef logic [1:0] ctrlIxT;

	localparam int RegionMsb = 15;
	localparam int RegionLsb = 14;
	// region 2 is left unmapped
	localparam regionT RegionCells = 2'd0;
	localparam regionT RegionGlyphs = 2'd1;
	localparam regionT RegionCtrl = 2'd3;

	localparam int CellIxLsb = 4;
	localparam int WordMsb = 3;
	localparam int WordLsb = 2;
	localparam int GlyphMsb = 9;
	localparam int GlyphLsb = 3;
	localparam int HalfBit = 2;
	localparam int CtrlIxMsb = 3;
	localparam int CtrlIxLsb = 2;

	localparam ctrlIxT CtrlEnable = 2'd0;
	localparam ctrlIxT CtrlBase = 2'd1;

	typedef struct packed {
		hostAddrT addr;
		logic write;
		hostWordT writeData;
	} hostReqT;

endpackage

`default_nettype wire

// ==== source/hostPort.sv ====
// Host side of the display: turns a four-phase req/ack transaction into
// exactly one memory access and holds its result until the host lets go.
`timescale 1ns/1ns
`default_nettype none

module hostPort
	import hostBusPkg::*;
(
	input wire logic clock,
	input wire logic rstN,
	input wire logic hostReq,
	input wire hostAddrT hostAddr,
	input wire logic hostWrite,
	input wire hostWordT hostWriteData,
	output logic hostAck,
	output hostWordT hostReadData,
	output logic hostOkay,
	memPortIf.requester mem
);

	typedef enum logic [1:0] {
		StateIdle,
		StateAccess,
		StateCapture,
		StateAcked
	} stateT;

	stateT state;

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			state <= StateIdle;
		else
		begin
			unique case (state)
				StateIdle: if (hostReq) state <= StateAccess;
				StateAccess: state <= StateCapture;
				StateCapture: state <= StateAcked;
				// held here while the host keeps req high
				StateAcked: if (!hostReq) state <= StateIdle;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == StateIdle && hostReq)
			mem.payload <= hostReqT'{addr: hostAddr, write: hostWrite, writeData: hostWriteData};
		if (state == StateCapture)
		begin
			hostReadData <= mem.readData;
			hostOkay <= mem.okay;
		end
	end

	assign mem.access = (state == StateAccess);
	assign hostAck = (state == StateAcked);

endmodule

`default_nettype wire

// ==== source/memPortIf.sv ====
// Single-cycle memory access port.
// The requester pulses access with a payload; readData and okay follow
// one cycle later. Payload and read data types are set per instance.
`timescale 1ns/1ns
`default_nettype none

interface memPortIf #(
	parameter type payloadT = logic [31:0],
	parameter type dataT = logic [31:0]
);

	logic access;
	payloadT payload;
	dataT readData;
	logic okay;

	modport requester
	(
		output access,
		output payload,
		input readData,
		input okay
	);

	modport memory
	(
		input access,
		input payload,
		output readData,
		output okay
	);

endinterface

`default_nettype wire

// ==== source/scanOut.sv ====
// Scan-out engine. While enabled it walks column, scanline and text row,
// issuing one cell index per cycle. Cell and glyph row come back through a
// three stage pipeline and leave as registered pixel slices.
`timescale 1ns/1ns
`default_nettype none

module scanOut
	import textModePkg::*;
#(
	parameter int Columns = 8,
	parameter int TextRows = 4
)
(
	input wire logic clock,
	input wire logic rstN,
	input wire logic scanEnable,
	input wire cellIxT scanBase,
	memPortIf.requester cells,
	output glyphCodeT glyphIx,
	input wire glyphT glyphData,
	output logic pixValid,
	output pixSliceT pixSlice
);

	localparam int ColW = (Columns > 1) ? $clog2(Columns) : 1;
	localparam int RowW = (TextRows > 1) ? $clog2(TextRows) : 1;

	logic [ColW-1:0] col;
	lineT line;
	logic [RowW-1:0] row;
	cellIxT rowStart;
	logic lastCol;
	logic lastLine;
	logic lastRow;

	logic s1Valid;
	cellIxT s1Ix;
	lineT s1Line;
	logic s2Valid;
	cellIxT s2Ix;
	lineT s2Line;
	colorT s2Fg;
	colorT s2Bg;
	cellWord0T word0;

	assign lastCol = (col == ColW'(Columns - 1));
	assign lastLine = &line;
	assign lastRow = (row == RowW'(TextRows - 1));

	assign cells.access = scanEnable;
	assign cells.payload = scanBase + rowStart + cellIxT'(col);

	// stage 1, cell word 0 picks the glyph
	assign word0 = cellWord0T'(cells.readData[0]);
	assign glyphIx = word0.code;

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			col <= '0;
			line <= '0;
			row <= '0;
			rowStart <= '0;
		end
		else if (!scanEnable)
		begin
			// next enable starts again at the base cell
			col <= '0;
			line <= '0;
			row <= '0;
			rowStart <= '0;
		end
		else
		begin
			col <= lastCol ? '0 : col + 1'b1;
			if (lastCol)
			begin
				line <= line + 1'b1;
				if (lastLine)
				begin
					row <= lastRow ? '0 : row + 1'b1;
					rowStart <= lastRow ? '0 : rowStart + cellIxT'(Columns);
				end
			end
		end
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
			pixValid <= 1'b0;
		end
		else
		begin
			s1Valid <= scanEnable;
			s2Valid <= s1Valid;
			pixValid <= s2Valid;
		end
	end

	always_ff @(posedge clock)
	begin
		s1Ix <= cells.payload;
		s1Line <= line;
		s2Ix <= s1Ix;
		s2Line <= s1Line;
		s2Fg <= word0.fg;
		s2Bg <= word0.bg;
		// stage 3, pick this scanline out of the glyph
		pixSlice <= pixSliceT'{
			cellIx: s2Ix,
			line: s2Line,
			bits: glyphData[s2Line],
			fg: s2Fg,
			bg: s2Bg
		};
	end

endmodule

`default_nettype wire

// ==== source/textDisplayTop.sv ====
// Top level of the text display: host port, screen memory and scan-out.
// Geometry and memory depth are set here and passed down.
`timescale 1ns/1ns
`default_nettype none

module textDisplayTop
	import textModePkg::*;
	import hostBusPkg::*;
#(
	parameter int Columns = 8,
	parameter int TextRows = 4,
	parameter int CellDepth = 1024
)
(
	input wire logic clock,
	input wire logic rstN,
	input wire logic hostReq,
	input wire hostAddrT hostAddr,
	input wire logic hostWrite,
	input wire hostWordT hostWriteData,
	output logic hostAck,
	output hostWordT hostReadData,
	output logic hostOkay,
	output logic pixValid,
	output cellIxT pixCellIx,
	output lineT pixLine,
	output glyphRowT pixBits,
	output colorT pixFg,
	output colorT pixBg
);

	glyphCodeT glyphIx;
	glyphT glyphData;
	logic scanEnable;
	cellIxT scanBase;
	pixSliceT pixSlice;

	memPortIf #(.payloadT(hostReqT), .dataT(hostWordT)) hostBus ();
	// display side, okay is not used by the scan engine
	memPortIf #(.payloadT(cellIxT), .dataT(cellT)) cellBus ();

	hostPort uHostPort (
		.clock(clock),
		.rstN(rstN),
		.hostReq(hostReq),
		.hostAddr(hostAddr),
		.hostWrite(hostWrite),
		.hostWriteData(hostWriteData),
		.hostAck(hostAck),
		.hostReadData(hostReadData),
		.hostOkay(hostOkay),
		.mem(hostBus.requester)
	);

	textMemory #(.CellDepth(CellDepth)) uTextMemory (
		.clock(clock),
		.rstN(rstN),
		.hostSide(hostBus.memory),
		.scanSide(cellBus.memory),
		.glyphIx(glyphIx),
		.glyphData(glyphData),
		.scanEnable(scanEnable),
		.scanBase(scanBase)
	);

	scanOut #(.Columns(Columns), .TextRows(TextRows)) uScanOut (
		.clock(clock),
		.rstN(rstN),
		.scanEnable(scanEnable),
		.scanBase(scanBase),
		.cells(cellBus.requester),
		.glyphIx(glyphIx),
		.glyphData(glyphData),
		.pixValid(pixValid),
		.pixSlice(pixSlice)
	);

	assign pixCellIx = pixSlice.cellIx;
	assign pixLine = pixSlice.line;
	assign pixBits = pixSlice.bits;
	assign pixFg = pixSlice.fg;
	assign pixBg = pixSlice.bg;

endmodule

`default_nettype wire

// ==== source/textMemory.sv ====
// Screen memory of the text display.
// Cells live in four 32-bit word lanes, glyphs in two 32-bit halves, plus
// the enable and base control registers. The host port reads and writes one
// word per access; the display port reads a whole cell and one glyph per
// cycle, both with one cycle of latency.
`timescale 1ns/1ns
`default_nettype none

module textMemory
	import textModePkg::*;
	import hostBusPkg::*;
#(
	parameter int CellDepth = 1024
)
(
	input wire logic clock,
	input wire logic rstN,
	memPortIf.memory hostSide,
	memPortIf.memory scanSide,
	input wire glyphCodeT glyphIx,
	output glyphT glyphData,
	output logic scanEnable,
	output cellIxT scanBase
);

	localparam int CellAw = $clog2(CellDepth);

	hostReqT req;
	regionT region;
	logic [1:0] wordSel;
	logic [CellAw-1:0] hostCellIx;
	logic [CellAw-1:0] scanCellIx;
	glyphCodeT hostGlyphIx;
	logic glyphHalf;
	ctrlIxT ctrlIx;
	logic mapped;
	logic cellWrite;
	logic glyphWrite;
	logic ctrlWrite;
	hostWordT readMux;

	cellWordT cellRam [CellWords][CellDepth];
	hostWordT glyphLo [GlyphCount];
	hostWordT glyphHi [GlyphCount];

	assign req = hostSide.payload;
	assign region = req.addr[RegionMsb:RegionLsb];
	assign wordSel = req.addr[WordMsb:WordLsb];
	assign hostCellIx = req.addr[CellIxLsb +: CellAw];
	assign hostGlyphIx = req.addr[GlyphMsb:GlyphLsb];
	assign glyphHalf = req.addr[HalfBit];
	assign ctrlIx = req.addr[CtrlIxMsb:CtrlIxLsb];
	assign scanCellIx = scanSide.payload[CellAw-1:0];

	assign cellWrite = hostSide.access && req.write && region == RegionCells;
	assign glyphWrite = hostSide.access && req.write && region == RegionGlyphs;
	assign ctrlWrite = hostSide.access && req.write && region == RegionCtrl;

	// region 2 and control indices 2, 3 answer not okay
	always_comb
	begin
		mapped = 1'b0;
		readMux = '0;
		case (region)
			RegionCells:
			begin
				mapped = 1'b1;
				readMux = cellRam[wordSel][hostCellIx];
			end
			RegionGlyphs:
			begin
				mapped = 1'b1;
				readMux = glyphHalf ? glyphHi[hostGlyphIx] : glyphLo[hostGlyphIx];
			end
			RegionCtrl:
			begin
				mapped = (ctrlIx == CtrlEnable) || (ctrlIx == CtrlBase);
				if (ctrlIx == CtrlEnable)
					readMux = {31'b0, scanEnable};
				else if (ctrlIx == CtrlBase)
					readMux = hostWordT'(scanBase);
			end
			default:
			begin
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		// one lane per write, the other three words are left alone
		if (cellWrite)
			cellRam[wordSel][hostCellIx] <= req.writeData;
		if (glyphWrite && !glyphHalf)
			glyphLo[hostGlyphIx] <= req.writeData;
		if (glyphWrite && glyphHalf)
			glyphHi[hostGlyphIx] <= req.writeData;
		if (hostSide.access)
			hostSide.readData <= readMux;
		if (scanSide.access)
		begin
			for (int lane = 0; lane < CellWords; lane++)
				scanSide.readData[lane] <= cellRam[lane][scanCellIx];
		end
		glyphData <= {glyphHi[glyphIx], glyphLo[glyphIx]};
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			scanEnable <= 1'b0;
			scanBase <= '0;
			hostSide.okay <= 1'b0;
			scanSide.okay <= 1'b0;
		end
		else
		begin
			if (hostSide.access)
				hostSide.okay <= mapped;
			scanSide.okay <= scanSide.access;
			if (ctrlWrite && ctrlIx == CtrlEnable)
				scanEnable <= req.writeData[0];
			if (ctrlWrite && ctrlIx == CtrlBase)
				scanBase <= req.writeData[9:0];
		end
	end

endmodule

`default_nettype wire

// ==== source/textModePkg.sv ====
// Screen geometry, cell layout and pixel slice types of the text display.
// Shared by the memory block, the scan-out engine and the top level.
`default_nettype none

package textModePkg;

	// a cell is four 32-bit words, word 0 selects glyph and colors
	localparam int CellWords = 4;
	localparam int GlyphCount = 128;
	localparam int GlyphRows = 8;

	typedef logic [9:0] cellIxT;
	typedef logic [2:0] lineT;
	typedef logic [3:0] colorT;
	typedef logic [6:0] glyphCodeT;
	typedef logic [31:0] cellWordT;
	typedef cellWordT [CellWords-1:0] cellT;

	typedef struct packed {
		logic [16:0] spare;
		colorT bg;
		colorT fg;
		glyphCodeT code;
	} cellWord0T;

	typedef logic [7:0] glyphRowT;
	// row 0 in the low byte
	typedef glyphRowT [GlyphRows-1:0] glyphT;

	typedef struct packed {
		cellIxT cellIx;
		lineT line;
		glyphRowT bits;
		colorT fg;
		colorT bg;
	} pixSliceT;

endpackage

`default_nettype wire

// ==== test/textDisplayTb.sv ====
// Testbench for the text display. Drives host req/ack transactions, keeps a
// model of cells, glyphs and control registers, and compares every pixel
// slice of the scan stream with a reference computed from that model.
// Stops at the first mismatch or timeout.
`timescale 1ns/1ns
`default_nettype none

module textDisplayTb
	import textModePkg::*;
	import hostBusPkg::*;
();

	localparam int Columns = 8;
	localparam int TextRows = 4;
	localparam int CellDepth = 1024;
	localparam int ScreenCells = Columns * TextRows;
	localparam int ScreenSlices = ScreenCells * GlyphRows;
	localparam int AckLimit = 20;

	logic clock;
	logic rstN;
	logic hostReq;
	hostAddrT hostAddr;
	logic hostWrite;
	hostWordT hostWriteData;
	logic hostAck;
	hostWordT hostReadData;
	logic hostOkay;
	logic pixValid;
	cellIxT pixCellIx;
	lineT pixLine;
	glyphRowT pixBits;
	colorT pixFg;
	colorT pixBg;

	// model of everything the host can see
	hostWordT cellModel [CellDepth][CellWords];
	hostWordT glyphLoModel [GlyphCount];
	hostWordT glyphHiModel [GlyphCount];
	logic enableModel;
	cellIxT baseModel;

	string testName;
	logic checkOn;
	int sliceCount;
	pixSliceT expSlice;
	pixSliceT actSlice;

	textDisplayTop #(.Columns(Columns), .TextRows(TextRows), .CellDepth(CellDepth)) DUT (
		.clock(clock),
		.rstN(rstN),
		.hostReq(hostReq),
		.hostAddr(hostAddr),
		.hostWrite(hostWrite),
		.hostWriteData(hostWriteData),
		.hostAck(hostAck),
		.hostReadData(hostReadData),
		.hostOkay(hostOkay),
		.pixValid(pixValid),
		.pixCellIx(pixCellIx),
		.pixLine(pixLine),
		.pixBits(pixBits),
		.pixFg(pixFg),
		.pixBg(pixBg)
	);

	always #50 clock = ~clock;

	function automatic hostAddrT cellAddr(input cellIxT ix, input logic [1:0] word);
		return {2'b00, ix, word, 2'b00};
	endfunction

	function automatic hostAddrT glyphAddr(input glyphCodeT code, input logic half);
		return {2'b01, 4'b0000, code, half, 2'b00};
	endfunction

	function automatic hostAddrT ctrlAddr(input logic [1:0] ix);
		return {2'b11, 10'b0, ix, 2'b00};
	endfunction

	function automatic logic isMapped(input hostAddrT a);
		case (a[15:14])
			2'd0, 2'd1: return 1'b1;
			2'd3: return a[3:2] < 2'd2;
			default: return 1'b0;
		endcase
	endfunction

	function automatic hostWordT modelRead(input hostAddrT a);
		case (a[15:14])
			2'd0: return cellModel[a[13:4]][a[3:2]];
			2'd1: return a[2] ? glyphHiModel[a[9:3]] : glyphLoModel[a[9:3]];
			2'd3: return (a[3:2] == 2'd0) ? {31'b0, enableModel} : {22'b0, baseModel};
			default: return '0;
		endcase
	endfunction

	task automatic modelWrite(input hostAddrT a, input hostWordT d);
		case (a[15:14])
			2'd0: cellModel[a[13:4]][a[3:2]] = d;
			2'd1:
			begin
				if (a[2])
					glyphHiModel[a[9:3]] = d;
				else
					glyphLoModel[a[9:3]] = d;
			end
			2'd3:
			begin
				if (a[3:2] == 2'd0)
					enableModel = d[0];
				else if (a[3:2] == 2'd1)
					baseModel = d[9:0];
			end
			default:
			begin
			end
		endcase
	endtask

	// slice k of a screen walk: column, then scanline, then text row
	function automatic pixSliceT expectSlice(input int k);
		int col;
		int line;
		int row;
		cellIxT ix;
		hostWordT w0;
		glyphCodeT code;
		logic [63:0] glyph;
		pixSliceT s;
		col = k % Columns;
		line = (k / Columns) % GlyphRows;
		row = (k / (Columns * GlyphRows)) % TextRows;
		ix = baseModel + cellIxT'(row * Columns + col);
		w0 = cellModel[ix][0];
		code = w0[6:0];
		glyph = {glyphHiModel[code], glyphLoModel[code]};
		s.cellIx = ix;
		s.line = lineT'(line);
		s.bits = glyph[line * 8 +: 8];
		s.fg = w0[10:7];
		s.bg = w0[14:11];
		return s;
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic hostTransfer(input hostAddrT addr, input logic write, input hostWordT data,
		input int hold, output hostWordT rdata, output logic okay);
		int waited;
		@(posedge clock);
		hostReq <= 1'b1;
		hostAddr <= addr;
		hostWrite <= write;
		hostWriteData <= data;
		waited = 0;
		do
		begin
			@(negedge clock);
			waited++;
		end
		while (!hostAck && waited < AckLimit);
		if (!hostAck)
			abortRun($sformatf("%s: no hostAck for address %h", testName, addr));
		rdata = hostReadData;
		okay = hostOkay;
		// host keeps req high, ack and result must not move
		for (int i = 0; i < hold; i++)
		begin
			@(negedge clock);
			assert (hostAck && hostReadData == rdata && hostOkay == okay)
			else
				abortRun($sformatf("CHECK FAILED %s: expected ack 1 data %h okay %b, %s%b %h %b",
					testName, rdata, okay, "actual ack data okay ", hostAck, hostReadData,
					hostOkay));
		end
		@(posedge clock);
		hostReq <= 1'b0;
		waited = 0;
		do
		begin
			@(negedge clock);
			waited++;
		end
		while (hostAck && waited < AckLimit);
		if (hostAck)
			abortRun($sformatf("%s: hostAck stayed high after hostReq was released", testName));
	endtask

	task automatic writeWord(input hostAddrT addr, input hostWordT data);
		hostWordT rd;
		logic ok;
		hostTransfer(addr, 1'b1, data, 0, rd, ok);
		assert (ok == isMapped(addr))
		else
			abortRun($sformatf("CHECK FAILED %s: write %h expected okay %b, actual %b",
				testName, addr, isMapped(addr), ok));
		modelWrite(addr, data);
	endtask

	task automatic readExpect(input hostAddrT addr, input int hold);
		hostWordT rd;
		logic ok;
		hostTransfer(addr, 1'b0, '0, hold, rd, ok);
		assert (ok == isMapped(addr))
		else
			abortRun($sformatf("CHECK FAILED %s: read %h expected okay %b, actual %b",
				testName, addr, isMapped(addr), ok));
		if (ok)
		begin
			assert (rd == modelRead(addr))
			else
				abortRun($sformatf("CHECK FAILED %s: read %h expected %h, actual %h",
					testName, addr, modelRead(addr), rd));
		end
	endtask

	task automatic waitSlices(input int count);
		int cycles;
		cycles = 0;
		while (sliceCount < count && cycles < count + 40)
		begin
			@(posedge clock);
			cycles++;
		end
		if (sliceCount < count)
			abortRun($sformatf("%s: scan output stopped after %0d slices", testName, sliceCount));
	endtask

	task automatic waitScanIdle();
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge clock);
			cycles++;
		end
		while (pixValid && cycles < AckLimit);
		if (pixValid)
			abortRun($sformatf("%s: pixValid stayed high after scanning was disabled", testName));
	endtask

	// every valid slice is compared while checking is on
	always @(negedge clock)
	begin
		if (rstN && checkOn && pixValid)
		begin
			expSlice = expectSlice(sliceCount);
			actSlice = '{cellIx: pixCellIx, line: pixLine, bits: pixBits, fg: pixFg, bg: pixBg};
			assert (actSlice == expSlice)
			else
				abortRun($sformatf("CHECK FAILED %s slice %0d: expected %h, actual %h",
					testName, sliceCount, expSlice, actSlice));
			sliceCount++;
		end
	end

	initial
	begin
		cellIxT ix;
		cellIxT lastIx;
		hostAddrT neighbor;
		hostAddrT addr;
		clock = 1'b0;
		rstN = 1'b0;
		hostReq = 1'b0;
		hostAddr = '0;
		hostWrite = 1'b0;
		hostWriteData = '0;
		enableModel = 1'b0;
		baseModel = '0;
		checkOn = 1'b0;
		sliceCount = 0;
		lastIx = '0;
		testName = "reset";
		void'($urandom(39));
		repeat (5) @(posedge clock);
		rstN <= 1'b1;

		// full cell, then one word rewritten alone
		testName = "cell words";
		for (int i = 0; i < 8; i++)
		begin
			ix = cellIxT'($urandom);
			for (int w = 0; w < CellWords; w++)
				writeWord(cellAddr(ix, 2'(w)), $urandom);
			writeWord(cellAddr(ix, 2'($urandom % 4)), $urandom);
			for (int w = 0; w < CellWords; w++)
				readExpect(cellAddr(ix, 2'(w)), 0);
			lastIx = ix;
		end

		testName = "glyph and base";
		for (int i = 0; i < 6; i++)
		begin
			addr = glyphAddr(glyphCodeT'($urandom), 1'($urandom % 2));
			writeWord(addr, $urandom);
			readExpect(addr, 0);
		end
		writeWord(ctrlAddr(CtrlBase), $urandom);
		readExpect(ctrlAddr(CtrlBase), 0);

		testName = "unmapped";
		neighbor = cellAddr(lastIx, 2'd1);
		addr = {2'b10, neighbor[13:0]};
		writeWord(addr, $urandom);
		readExpect(addr, 0);
		readExpect(neighbor, 0);
		for (int i = 2; i < 4; i++)
		begin
			writeWord(ctrlAddr(2'(i)), 32'hffff_ffff);
			readExpect(ctrlAddr(2'(i)), 0);
		end
		readExpect(ctrlAddr(CtrlEnable), 0);
		readExpect(ctrlAddr(CtrlBase), 0);

		testName = "held request";
		for (int i = 0; i < CellWords; i++)
			readExpect(cellAddr(lastIx, 2'(i)), 1 + int'($urandom % 6));
		readExpect(ctrlAddr(CtrlBase), 1 + int'($urandom % 6));

		// whole screen from the base cell, every glyph loaded
		testName = "first screen";
		for (int i = 0; i < ScreenCells; i++)
			writeWord(cellAddr(baseModel + cellIxT'(i), 2'd0), $urandom);
		for (int g = 0; g < GlyphCount; g++)
		begin
			writeWord(glyphAddr(glyphCodeT'(g), 1'b0), $urandom);
			writeWord(glyphAddr(glyphCodeT'(g), 1'b1), $urandom);
		end
		sliceCount = 0;
		checkOn = 1'b1;
		writeWord(ctrlAddr(CtrlEnable), 32'd1);
		waitSlices(ScreenSlices);

		testName = "restart";
		checkOn = 1'b0;
		writeWord(cellAddr(baseModel + cellIxT'($urandom % ScreenCells), 2'd0), $urandom);
		writeWord(ctrlAddr(CtrlEnable), 32'd0);
		waitScanIdle();
		sliceCount = 0;
		checkOn = 1'b1;
		writeWord(ctrlAddr(CtrlEnable), 32'd1);
		waitSlices(ScreenSlices);
		checkOn = 1'b0;

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/textDisplay_chk.sv ====
// Concurrent checks on the text display, bound into the top level.
// Covers the host req/ack timing and the scanline order of the pixel stream.
`timescale 1ns/1ns
`default_nettype none

module textDisplayChk
	import textModePkg::*;
#(
	parameter int Columns = 8
)
(
	input wire logic clock,
	input wire logic rstN,
	input wire logic hostReq,
	input wire logic hostAck,
	input wire logic pixValid,
	input wire lineT pixLine
);

	// position of the current slice within its run of columns
	int colPos;

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			colPos <= 0;
		else if (!pixValid)
			colPos <= 0;
		else if (colPos == Columns - 1)
			colPos <= 0;
		else
			colPos <= colPos + 1;
	end

	ackDelay: assert property (@(posedge clock) disable iff (!rstN)
		$rose(hostReq) |-> !hostAck ##1 !hostAck ##1 !hostAck ##1 hostAck)
		else $error("hostAck did not rise exactly 3 cycles after hostReq");

	ackNeedsReq: assert property (@(posedge clock) disable iff (!rstN)
		$rose(hostAck) |-> hostReq)
		else $error("hostAck rose while hostReq was low");

	lineSteady: assert property (@(posedge clock) disable iff (!rstN)
		pixValid && $past(pixValid) && colPos != 0 |-> pixLine == $past(pixLine))
		else $error("pixLine changed inside a run of columns");

endmodule

bind textDisplayTop textDisplayChk #(.Columns(Columns)) uChk (
	.clock(clock),
	.rstN(rstN),
	.hostReq(hostReq),
	.hostAck(hostAck),
	.pixValid(pixValid),
	.pixLine(pixLine)
);

`default_nettype wire
